// File: raster.f
src/raster_pkg.sv
src/cmd_decoder.sv
src/raster_walker.sv
src/fragment_fifo.sv
src/vram_writer.sv
src/raster_top.sv
testbench/tb_raster_top.sv

// File: src/cmd_decoder.sv
`timescale 1ns/1ps

// command decoder
// takes command words, keeps the vertex, colour and base-address registers,
// and hands clear or draw jobs to the walker
module cmd_decoder import raster_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      cmd_valid_i,
    input  cmd_word_t cmd_data_i,
    output logic      cmd_ready_o,
    output logic      job_valid_o,
    output job_t      job_o,
    input  logic      job_ready_i,
    input  logic      done_i
);

    logic       busy_q;
    logic       accept;
    logic       launch;
    coord_t     coord_val;
    vertex_t    vtx_q [3];
    pixel_t     color_q;
    vram_addr_t base_q;

    assign cmd_ready_o = !busy_q;
    assign accept      = cmd_valid_i && !busy_q;
    assign launch      = accept &&
                         (cmd_data_i.opcode == OP_CLEAR || cmd_data_i.opcode == OP_DRAW);
    assign coord_val   = cmd_data_i.value[COORD_BITS-1:0];

    // busy from job launch until the walker is finished with it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            job_valid_o <= 1'b0;
            base_q      <= '0;
        end else begin
            if (launch) begin
                busy_q      <= 1'b1;
                job_valid_o <= 1'b1;
            end else begin
                if (job_valid_o && job_ready_i) begin
                    job_valid_o <= 1'b0;
                end
                if (done_i) begin
                    busy_q <= 1'b0;
                end
            end
            if (accept && cmd_data_i.opcode == OP_SET_FB_ADDR) begin
                if (cmd_data_i.half) begin
                    base_q[31:16] <= cmd_data_i.value;
                end else begin
                    base_q[15:0] <= cmd_data_i.value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (cmd_data_i.opcode)
                OP_SET_X0:    vtx_q[0].x <= coord_val;
                OP_SET_Y0:    vtx_q[0].y <= coord_val;
                OP_SET_X1:    vtx_q[1].x <= coord_val;
                OP_SET_Y1:    vtx_q[1].y <= coord_val;
                OP_SET_X2:    vtx_q[2].x <= coord_val;
                OP_SET_Y2:    vtx_q[2].y <= coord_val;
                OP_SET_COLOR: color_q    <= cmd_data_i.value;
                default: begin
                end
            endcase
        end
        if (launch) begin
            job_o.is_clear <= (cmd_data_i.opcode == OP_CLEAR);
            job_o.v0       <= vtx_q[0];
            job_o.v1       <= vtx_q[1];
            job_o.v2       <= vtx_q[2];
            // clear carries its colour in the command itself
            job_o.color    <= (cmd_data_i.opcode == OP_CLEAR) ? cmd_data_i.value : color_q;
            job_o.base     <= base_q;
        end
    end

endmodule

// File: src/fragment_fifo.sv
`timescale 1ns/1ps

// synchronous FIFO, generic over its payload type
// circular buffer with read and write pointers and an occupancy count
module fragment_fifo import raster_pkg::*; #(
    parameter type payload_t = fragment_t
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     push_valid_i,
    input  payload_t push_data_i,
    output logic     push_ready_o,
    output logic     pop_valid_o,
    output payload_t pop_data_o,
    input  logic     pop_ready_i
);

    payload_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]    wr_ptr, rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]  count;
    logic                             do_push, do_pop;

    assign push_ready_o = (count != FIFO_DEPTH);
    assign pop_valid_o  = (count != 0);
    assign pop_data_o   = mem[rd_ptr];
    assign do_push      = push_valid_i && push_ready_o;
    assign do_pop       = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

// File: src/raster_pkg.sv
// raster engine shared definitions
// framebuffer geometry, command opcodes and the structs passed between
// the decoder, walker, fragment FIFO and VRAM writer
package raster_pkg;

    // framebuffer geometry
    localparam int FB_WIDTH   = 16;
    localparam int FB_HEIGHT  = 16;
    localparam int FB_PIXELS  = FB_WIDTH * FB_HEIGHT;

    // 12-bit coordinates give 13-bit deltas, 26-bit products, 27-bit edge values
    localparam int COORD_BITS = 12;
    localparam int EDGE_BITS  = 27;

    localparam int FIFO_DEPTH = 8;

    typedef logic signed [COORD_BITS-1:0] coord_t;
    typedef logic [15:0]                  pixel_t;
    typedef logic [31:0]                  vram_addr_t;

    typedef enum logic [7:0] {
        OP_SET_X0      = 8'd0,
        OP_SET_Y0      = 8'd1,
        OP_SET_X1      = 8'd2,
        OP_SET_Y1      = 8'd3,
        OP_SET_X2      = 8'd4,
        OP_SET_Y2      = 8'd5,
        OP_SET_COLOR   = 8'd6,
        OP_SET_FB_ADDR = 8'd7,
        OP_CLEAR       = 8'd8,
        OP_DRAW        = 8'd9
    } opcode_t;

    // command word as seen on the stream
    typedef struct packed {
        opcode_t     opcode;
        logic [6:0]  reserved;
        logic        half;
        logic [15:0] value;
    } cmd_word_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // one clear or draw request, snapshot of the decoder registers
    typedef struct packed {
        logic       is_clear;
        vertex_t    v0;
        vertex_t    v1;
        vertex_t    v2;
        pixel_t     color;
        vram_addr_t base;
    } job_t;

    typedef struct packed {
        vram_addr_t addr;
        pixel_t     data;
    } fragment_t;

endpackage

// File: src/raster_top.sv
`timescale 1ns/1ps

// pixel engine top level
// command decoder, pixel walker, fragment FIFO and VRAM writer in a chain
module raster_top import raster_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       cmd_valid_i,
    input  cmd_word_t  cmd_data_i,
    output logic       cmd_ready_o,
    output logic       vram_wr_o,
    output vram_addr_t vram_addr_o,
    output pixel_t     vram_data_o,
    input  logic       vram_wait_i
);

    logic      job_valid, job_ready, done;
    job_t      job;
    logic      push_valid, push_ready;
    fragment_t push_data;
    logic      pop_valid, pop_ready;
    fragment_t pop_data;

    cmd_decoder i_decoder (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_data_i  (cmd_data_i),
        .cmd_ready_o (cmd_ready_o),
        .job_valid_o (job_valid),
        .job_o       (job),
        .job_ready_i (job_ready),
        .done_i      (done)
    );

    raster_walker i_walker (
        .clk          (clk),
        .reset_i      (reset_i),
        .job_valid_i  (job_valid),
        .job_i        (job),
        .job_ready_o  (job_ready),
        .done_o       (done),
        .push_valid_o (push_valid),
        .push_data_o  (push_data),
        .push_ready_i (push_ready)
    );

    fragment_fifo #(
        .payload_t (fragment_t)
    ) i_fifo (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_data_o   (pop_data),
        .pop_ready_i  (pop_ready)
    );

    vram_writer i_writer (
        .clk         (clk),
        .reset_i     (reset_i),
        .pop_valid_i (pop_valid),
        .pop_data_i  (pop_data),
        .pop_ready_o (pop_ready),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .vram_wait_i (vram_wait_i)
    );

endmodule

// File: src/raster_walker.sv
`timescale 1ns/1ps

// pixel walker
// scans the clipped bounding box row by row, tests each pixel against three
// edge functions in a two-stage pipeline and pushes covered pixels as fragments
module raster_walker import raster_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      job_valid_i,
    input  job_t      job_i,
    output logic      job_ready_o,
    output logic      done_o,
    output logic      push_valid_o,
    output fragment_t push_data_o,
    input  logic      push_ready_i
);

    typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_RUN, ST_FLUSH} state_t;

    state_t     state;
    job_t       job_q;
    vertex_t    vtx [3];
    coord_t     box_min_x, box_min_y, box_max_x, box_max_y;
    logic       box_empty;
    coord_t     min_x, max_x, max_y;
    coord_t     px, py;
    logic       last_px;
    logic       stall;
    logic       issue;
    logic       s1_valid, s1_last;
    vram_addr_t s1_addr;
    logic [2:0] edge_neg;
    logic       covered;
    logic       s2_last;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    assign vtx[0] = job_q.v0;
    assign vtx[1] = job_q.v1;
    assign vtx[2] = job_q.v2;

    // bounding box clipped to the framebuffer, whole frame for clear
    always_comb begin
        if (job_q.is_clear) begin
            box_min_x = '0;
            box_min_y = '0;
            box_max_x = coord_t'(FB_WIDTH - 1);
            box_max_y = coord_t'(FB_HEIGHT - 1);
        end else begin
            box_min_x = min3(vtx[0].x, vtx[1].x, vtx[2].x);
            box_min_y = min3(vtx[0].y, vtx[1].y, vtx[2].y);
            box_max_x = max3(vtx[0].x, vtx[1].x, vtx[2].x);
            box_max_y = max3(vtx[0].y, vtx[1].y, vtx[2].y);
            if (box_min_x < 0) begin
                box_min_x = '0;
            end
            if (box_min_y < 0) begin
                box_min_y = '0;
            end
            if (box_max_x > coord_t'(FB_WIDTH - 1)) begin
                box_max_x = coord_t'(FB_WIDTH - 1);
            end
            if (box_max_y > coord_t'(FB_HEIGHT - 1)) begin
                box_max_y = coord_t'(FB_HEIGHT - 1);
            end
        end
        box_empty = (box_min_x > box_max_x) || (box_min_y > box_max_y);
    end

    assign job_ready_o = (state == ST_IDLE);
    assign stall       = push_valid_o && !push_ready_i;
    assign issue       = (state == ST_RUN);
    assign last_px     = (px == max_x) && (py == max_y);
    assign covered     = job_q.is_clear || !(|edge_neg);
    assign done_o      = (s2_last && !stall) || (state == ST_SETUP && box_empty);

    // edge i runs from vertex i+1 to vertex i+2, two products per edge in stage 1
    for (genvar i = 0; i < 3; i++) begin : g_edge
        logic signed [COORD_BITS:0]  dpx, dpy, dex, dey;
        logic signed [EDGE_BITS-1:0] prod_a_q, prod_b_q;
        logic signed [EDGE_BITS-1:0] w;

        assign dpx = px - vtx[(i + 1) % 3].x;
        assign dpy = py - vtx[(i + 1) % 3].y;
        assign dex = vtx[(i + 2) % 3].x - vtx[(i + 1) % 3].x;
        assign dey = vtx[(i + 2) % 3].y - vtx[(i + 1) % 3].y;

        always_ff @(posedge clk) begin
            if (!stall) begin
                prod_a_q <= dpx * dey;
                prod_b_q <= dpy * dex;
            end
        end

        assign w           = prod_a_q - prod_b_q;
        assign edge_neg[i] = w[EDGE_BITS-1];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (job_valid_i) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: state <= box_empty ? ST_IDLE : ST_RUN;
                ST_RUN: begin
                    if (!stall && last_px) begin
                        state <= ST_FLUSH;
                    end
                end
                ST_FLUSH: begin
                    if (done_o) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // pipeline valid and last flags
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid     <= 1'b0;
            s1_last      <= 1'b0;
            s2_last      <= 1'b0;
            push_valid_o <= 1'b0;
        end else if (!stall) begin
            s1_valid     <= issue;
            s1_last      <= issue && last_px;
            s2_last      <= s1_last;
            push_valid_o <= s1_valid && covered;
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid_i && job_ready_o) begin
            job_q <= job_i;
        end
        if (state == ST_SETUP) begin
            min_x <= box_min_x;
            max_x <= box_max_x;
            max_y <= box_max_y;
            px    <= box_min_x;
            py    <= box_min_y;
        end else if (issue && !stall) begin
            if (px == max_x) begin
                px <= min_x;
                py <= py + coord_t'(1);
            end else begin
                px <= px + coord_t'(1);
            end
        end
        if (!stall) begin
            s1_addr <= job_q.base + vram_addr_t'(py) * FB_WIDTH + vram_addr_t'(px);
            push_data_o.addr <= s1_addr;
            push_data_o.data <= job_q.color;
        end
    end

endmodule

// File: src/vram_writer.sv
`timescale 1ns/1ps

// VRAM write port driver
// pops fragments into a registered write port and holds it while the memory waits
module vram_writer import raster_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       pop_valid_i,
    input  fragment_t  pop_data_i,
    output logic       pop_ready_o,
    output logic       vram_wr_o,
    output vram_addr_t vram_addr_o,
    output pixel_t     vram_data_o,
    input  logic       vram_wait_i
);

    logic load;

    // port is free when empty or its write completes on this edge
    assign pop_ready_o = !vram_wr_o || !vram_wait_i;
    assign load        = pop_valid_i && pop_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_wr_o <= 1'b0;
        end else if (load) begin
            vram_wr_o <= 1'b1;
        end else if (!vram_wait_i) begin
            vram_wr_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            vram_addr_o <= pop_data_i.addr;
            vram_data_o <= pop_data_i.data;
        end
    end

endmodule

// File: testbench/tb_raster_top.sv
`timescale 1ns/1ps

// testbench for the pixel engine
// runs clear and triangle jobs with and without VRAM wait states and
// compares every completed VRAM write against a coverage model
module tb_raster_top import raster_pkg::*; ();

    // 7 jobs per pass, two passes, each job at most one full frame
    localparam int NUM_JOBS       = 14;
    localparam int TIMEOUT_CYCLES = 4 * NUM_JOBS * FB_PIXELS + 1000;

    logic       clk;
    logic       reset_i;
    logic       cmd_valid_i;
    cmd_word_t  cmd_data_i;
    logic       cmd_ready_o;
    logic       vram_wr_o;
    vram_addr_t vram_addr_o;
    pixel_t     vram_data_o;
    logic       vram_wait_i;

    logic [31:0] lfsr;
    logic        wait_mode;
    int          cycles;
    int          errors;
    int          tests;
    int          failed_tests;
    int          dups;
    pixel_t      sb [vram_addr_t];

    // model state mirrors the decoder registers
    int          mx [3];
    int          my [3];
    vram_addr_t  model_base;

    raster_top i_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_data_i  (cmd_data_i),
        .cmd_ready_o (cmd_ready_o),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .vram_wait_i (vram_wait_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk) begin
        if (wait_mode) begin
            lfsr = lfsr_next(lfsr);
            vram_wait_i <= lfsr[0];
        end else begin
            vram_wait_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the engine never went idle", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // a write completes on the coming edge when wait is low
    always @(negedge clk) begin
        if (!reset_i && vram_wr_o && !vram_wait_i) begin
            if (sb.exists(vram_addr_o)) begin
                dups++;
            end
            sb[vram_addr_o] = vram_data_o;
        end
    end

    assert property (@(posedge clk) reset_i |=> !vram_wr_o)
    else begin
        errors++;
        $display("Fail at %0t: vram_wr_o during reset expected 0 got %b",
                 $time, $sampled(vram_wr_o));
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (vram_wr_o && vram_wait_i) |=>
        (vram_wr_o && $stable(vram_addr_o) && $stable(vram_data_o)))
    else begin
        errors++;
        $display("Fail at %0t: VRAM port changed while vram_wait_i was high", $time);
    end

    task automatic send_cmd(input opcode_t op, input logic half, input logic [15:0] value);
        cmd_word_t w;
        w          = '0;
        w.opcode   = op;
        w.half     = half;
        w.value    = value;
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_data_i  <= w;
        do begin
            @(negedge clk);
        end while (!cmd_ready_o);
        @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic set_triangle(input int x0, input int y0, input int x1, input int y1,
                                input int x2, input int y2);
        send_cmd(OP_SET_X0, 1'b0, 16'(x0));
        send_cmd(OP_SET_Y0, 1'b0, 16'(y0));
        send_cmd(OP_SET_X1, 1'b0, 16'(x1));
        send_cmd(OP_SET_Y1, 1'b0, 16'(y1));
        send_cmd(OP_SET_X2, 1'b0, 16'(x2));
        send_cmd(OP_SET_Y2, 1'b0, 16'(y2));
        mx = '{x0, x1, x2};
        my = '{y0, y1, y2};
    endtask

    task automatic set_base(input vram_addr_t base);
        send_cmd(OP_SET_FB_ADDR, 1'b1, base[31:16]);
        send_cmd(OP_SET_FB_ADDR, 1'b0, base[15:0]);
        model_base = base;
    endtask

    // idle once ready and no write has shown up for a while
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < FIFO_DEPTH + 4) begin
            @(negedge clk);
            if (cmd_ready_o && !vram_wr_o) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    // signed side of point p relative to the line from a to b
    function automatic int edge_value(input int ax, input int ay, input int bx, input int by,
                                      input int px, input int py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic bit covers(input int px, input int py);
        int w0;
        int w1;
        int w2;
        w0 = edge_value(mx[1], my[1], mx[2], my[2], px, py);
        w1 = edge_value(mx[2], my[2], mx[0], my[0], px, py);
        w2 = edge_value(mx[0], my[0], mx[1], my[1], px, py);
        return (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
    endfunction

    task automatic run_job(input string name, input bit is_clear, input pixel_t color);
        pixel_t     exp_map [vram_addr_t];
        vram_addr_t a;
        int         errs_before;
        errs_before = errors;
        sb.delete();
        dups = 0;
        if (is_clear) begin
            send_cmd(OP_CLEAR, 1'b0, color);
        end else begin
            send_cmd(OP_SET_COLOR, 1'b0, color);
            send_cmd(OP_DRAW, 1'b0, 16'h0);
        end
        wait_idle();
        for (int py = 0; py < FB_HEIGHT; py++) begin
            for (int px = 0; px < FB_WIDTH; px++) begin
                if (is_clear || covers(px, py)) begin
                    a          = model_base + vram_addr_t'(py * FB_WIDTH + px);
                    exp_map[a] = color;
                end
            end
        end
        foreach (exp_map[k]) begin
            assert (sb.exists(k)) else begin
                errors++;
                $display("Fail at %0t: no write to address %h", $time, k);
            end
            if (sb.exists(k)) begin
                assert (sb[k] == exp_map[k]) else begin
                    errors++;
                    $display("Fail at %0t: vram_data_o at %h expected %h got %h",
                             $time, k, exp_map[k], sb[k]);
                end
            end
        end
        assert (sb.num() == exp_map.num()) else begin
            errors++;
            $display("Fail at %0t: write count expected %0d got %0d",
                     $time, exp_map.num(), sb.num());
        end
        assert (dups == 0) else begin
            errors++;
            $display("Fail at %0t: duplicate writes expected 0 got %0d", $time, dups);
        end
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %s: %s", name, (errors == errs_before) ? "ok" : "errors");
    endtask

    initial begin
        string mode;
        reset_i      = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_data_i   = '0;
        vram_wait_i  = 1'b0;
        wait_mode    = 1'b0;
        lfsr         = 32'h358d577a;
        cycles       = 0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        dups         = 0;
        model_base   = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        assert (vram_wr_o == 1'b0) else begin
            errors++;
            $display("Fail at %0t: vram_wr_o after reset expected 0 got %b",
                     $time, vram_wr_o);
        end
        assert (cmd_ready_o == 1'b1) else begin
            errors++;
            $display("Fail at %0t: cmd_ready_o after reset expected 1 got %b",
                     $time, cmd_ready_o);
        end
        tests++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "errors");

        for (int pass = 0; pass < 2; pass++) begin
            wait_mode = (pass == 1);
            mode      = (pass == 1) ? "random wait" : "no wait";
            set_base(32'h0);
            run_job($sformatf("clear, %s", mode), 1'b1, 16'ha5c3);
            set_triangle(2, 1, 3, 13, 14, 6);
            run_job($sformatf("draw inside, %s", mode), 1'b0, 16'h1234);
            set_triangle(-5, -3, 4, 20, 22, 2);
            run_job($sformatf("draw clipped, %s", mode), 1'b0, 16'hbeef);
            set_triangle(8, -10, -12, 25, 30, 12);
            run_job($sformatf("draw large, %s", mode), 1'b0, 16'h0f0f);
            set_triangle(2, 1, 14, 6, 3, 13);
            run_job($sformatf("clockwise, %s", mode), 1'b0, 16'h7777);
            set_base(32'h0001_2340);
            run_job($sformatf("clear at base, %s", mode), 1'b1, 16'h5a5a);
            set_triangle(2, 1, 3, 13, 14, 6);
            run_job($sformatf("draw at base, %s", mode), 1'b0, 16'hc001);
        end

        $display("tests run %0d, tests with errors %0d, failed checks %0d",
                 tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
